// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = music_tb
FILELIST  = src.f
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: rtl/milli_timer.sv
`default_nettype none

module milli_timer (
  input  wire                 clk,
  input  wire                 rst,
  input  wire music_pkg::cfg_t cfg,
  output logic                ms_tick
);

  logic [15:0] cnt;
  logic        wrap;

  assign wrap = (cnt >= cfg.ticks_per_milli - 16'd1);  // also catches a lowered tpm

  always_ff @(posedge clk) begin
    if (rst || !cfg.play) begin
      cnt     <= '0;
      ms_tick <= 1'b0;
    end else begin
      ms_tick <= wrap;
      if (wrap) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 16'd1;
      end
    end
  end

  a_tick_single: assert property (
    @(posedge clk) disable iff (rst)
    (cfg.ticks_per_milli > 16'd1) && ms_tick |=> !ms_tick
  ) else $error("milli_timer: back to back ms_tick");

endmodule

`default_nettype wire

// File: rtl/music_pkg.sv
`default_nettype none

package music_pkg;

  localparam int FREQ_W   = 10;
  localparam int RHYTHM_W = 4;
  localparam int PART_W   = 3;
  localparam int TPM_W    = 16;
  localparam int BEAT_W   = 10;

  localparam int NUM_PARTS          = 6;
  localparam int MS_PER_HALF_SECOND = 500;  // half a tone period scale

  typedef logic [FREQ_W-1:0]   freq_t;    // Hz, 0 is a rest
  typedef logic [RHYTHM_W-1:0] rhythm_t;  // beat units
  typedef logic [PART_W-1:0]   part_t;    // 0 stopped, 1..6 playing

  typedef enum logic [1:0] {
    SEC_INTRO  = 2'd0,
    SEC_VERSE  = 2'd1,
    SEC_CHORUS = 2'd2
  } section_e;

  typedef struct packed {
    freq_t   freq;
    rhythm_t rhythm;
  } note_t;

  // software controlled settings
  typedef struct packed {
    logic              play;
    logic [TPM_W-1:0]  ticks_per_milli;
    logic [BEAT_W-1:0] beat_ms;
  } cfg_t;

  typedef struct packed {
    part_t part;
    freq_t freq;
  } status_t;

endpackage

`default_nettype wire

// File: rtl/music_regs.sv
`default_nettype none

module music_regs (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [3:0]            paddr,
  input  wire                   psel,
  input  wire                   penable,
  input  wire                   pwrite,
  input  wire  [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic                  pready,
  output logic                  pslverr,
  output music_pkg::cfg_t       cfg,
  input  wire music_pkg::status_t status
);

  localparam logic [3:0] ADDR_CTRL   = 4'h0;
  localparam logic [3:0] ADDR_TPM    = 4'h4;
  localparam logic [3:0] ADDR_BEAT   = 4'h8;
  localparam logic [3:0] ADDR_STATUS = 4'hC;

  logic access;
  logic mapped;

  assign access = psel && penable;  // APB access phase
  assign pready = 1'b1;             // never stalls

  assign mapped = (paddr == ADDR_CTRL) || (paddr == ADDR_TPM) ||
                  (paddr == ADDR_BEAT) || (paddr == ADDR_STATUS);

  assign pslverr = access && (!mapped || (pwrite && paddr == ADDR_STATUS));

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg.play            <= 1'b0;
      cfg.ticks_per_milli <= 16'd1000;
      cfg.beat_ms         <= 10'd100;
    end else if (access && pwrite) begin
      case (paddr)
        ADDR_CTRL: cfg.play            <= pwdata[0];
        ADDR_TPM:  cfg.ticks_per_milli <= pwdata[15:0];
        ADDR_BEAT: cfg.beat_ms         <= pwdata[9:0];
        default:   ;                   // status and holes ignore writes
      endcase
    end
  end

  always_comb begin
    case (paddr)
      ADDR_CTRL:   prdata = 32'(cfg.play);
      ADDR_TPM:    prdata = 32'(cfg.ticks_per_milli);
      ADDR_BEAT:   prdata = 32'(cfg.beat_ms);
      ADDR_STATUS: prdata = 32'(status);
      default:     prdata = '0;
    endcase
  end

  // enable only in the second cycle of a selected transfer
  a_apb_phase: assert property (
    @(posedge clk) disable iff (rst)
    penable |-> psel && $past(psel)
  ) else $error("music_regs: penable without a setup phase");

endmodule

`default_nettype wire

// File: rtl/music_top.sv
`default_nettype none

module music_top #(
  parameter int INDEX_W = 5,
  parameter int ACC_W   = 32
) (
  input  wire         clk,
  input  wire         rst,
  input  wire  [3:0]  paddr,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        sound,
  output logic [6:0]  segments,
  output logic        dot
);

  import music_pkg::*;

  cfg_t               cfg;
  status_t            status;
  logic               ms_tick;
  section_e           section;
  logic [INDEX_W-1:0] index;
  logic [INDEX_W-1:0] last_index;
  note_t              note;
  freq_t              freq;
  part_t              part;
  logic               note_on;

  music_regs regs0 (
    .clk(clk), .rst(rst),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .cfg(cfg), .status(status)
  );

  milli_timer timer0 (.clk(clk), .rst(rst), .cfg(cfg), .ms_tick(ms_tick));

  song_rom #(.INDEX_W(INDEX_W)) rom0 (
    .section(section), .index(index), .note(note), .last_index(last_index)
  );

  note_sequencer #(.INDEX_W(INDEX_W)) seq0 (
    .clk(clk), .rst(rst), .cfg(cfg), .ms_tick(ms_tick),
    .note(note), .last_index(last_index),
    .section(section), .index(index), .freq(freq),
    .part(part), .note_on(note_on), .status(status)
  );

  tone_gen #(.ACC_W(ACC_W)) tone0 (
    .clk(clk), .rst(rst), .freq(freq), .cfg(cfg), .sound(sound)
  );

  seg_display disp0 (.part(part), .note_on(note_on), .segments(segments), .dot(dot));

endmodule

`default_nettype wire

// File: rtl/note_sequencer.sv
`default_nettype none

module note_sequencer #(
  parameter int INDEX_W = 5
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire music_pkg::cfg_t      cfg,
  input  wire                       ms_tick,
  input  wire music_pkg::note_t     note,
  input  wire [INDEX_W-1:0]         last_index,
  output music_pkg::section_e       section,
  output logic [INDEX_W-1:0]        index,
  output music_pkg::freq_t          freq,
  output music_pkg::part_t          part,
  output logic                      note_on,
  output music_pkg::status_t        status
);

  import music_pkg::*;

  localparam int LEN_W = 15;  // 1023 ms * 15 beats * 2

  typedef enum logic [1:0] {
    ST_LOAD,
    ST_NOTE,
    ST_GAP
  } state_e;

  state_e           state;
  logic [LEN_W-1:0] ms_cnt;
  logic [LEN_W-1:0] note_len;
  logic [LEN_W-1:0] gap_len;
  logic [LEN_W-1:0] len_calc;
  logic             is_verse;

  always_comb begin
    case (part)
      3'd3, 3'd5: section = SEC_VERSE;
      3'd4, 3'd6: section = SEC_CHORUS;
      default:    section = SEC_INTRO;  // parts 1, 2 and stopped
    endcase
  end

  assign is_verse = (section == SEC_VERSE);
  assign len_calc = (LEN_W'(cfg.beat_ms) * LEN_W'(note.rhythm)) << is_verse;

  assign status = '{part: part, freq: freq};

  always_ff @(posedge clk) begin
    if (rst || !cfg.play) begin
      state   <= ST_LOAD;
      part    <= '0;
      index   <= '0;
      freq    <= '0;
      note_on <= 1'b0;
      ms_cnt  <= '0;
    end else if (part == '0) begin
      part  <= part_t'(1);  // play just rose
      index <= '0;
      state <= ST_LOAD;
    end else begin
      case (state)
        ST_LOAD: begin
          note_len <= len_calc;
          gap_len  <= len_calc / 3;
          freq     <= note.freq;  // 0 for a rest
          note_on  <= 1'b1;
          ms_cnt   <= '0;
          state    <= ST_NOTE;
        end
        ST_NOTE: begin
          if (ms_cnt >= note_len) begin
            freq    <= '0;
            note_on <= 1'b0;
            ms_cnt  <= '0;
            state   <= ST_GAP;
          end else if (ms_tick) begin
            ms_cnt <= ms_cnt + LEN_W'(1);
          end
        end
        ST_GAP: begin
          if (ms_cnt >= gap_len) begin
            state <= ST_LOAD;
            if (index == last_index) begin
              index <= '0;
              part  <= (part == part_t'(NUM_PARTS)) ? part_t'(1) : part + part_t'(1);
            end else begin
              index <= index + INDEX_W'(1);
            end
          end else if (ms_tick) begin
            ms_cnt <= ms_cnt + LEN_W'(1);
          end
        end
        default: state <= ST_LOAD;
      endcase
    end
  end

  a_part_range: assert property (
    @(posedge clk) disable iff (rst)
    part <= part_t'(NUM_PARTS)
  ) else $error("note_sequencer: part out of range");

endmodule

`default_nettype wire

// File: rtl/seg_display.sv
`default_nettype none

module seg_display (
  input  wire music_pkg::part_t part,
  input  wire                   note_on,
  output logic [6:0]            segments,
  output logic                  dot
);

  logic [3:0] digit;

  assign digit = {1'b0, part};
  assign dot   = note_on;  // lit while a note sounds

  // bit order g f e d c b a
  always_comb begin
    case (digit)
      4'd0:    segments = 7'b0111111;
      4'd1:    segments = 7'b0000110;
      4'd2:    segments = 7'b1011011;
      4'd3:    segments = 7'b1001111;
      4'd4:    segments = 7'b1100110;
      4'd5:    segments = 7'b1101101;
      4'd6:    segments = 7'b1111100;
      4'd7:    segments = 7'b0000111;
      4'd8:    segments = 7'b1111111;
      4'd9:    segments = 7'b1100111;
      default: segments = 7'b0000000;  // blank
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/song_rom.sv
`default_nettype none

module song_rom #(
  parameter int INDEX_W = 5
) (
  input  wire music_pkg::section_e section,
  input  wire [INDEX_W-1:0]        index,
  output music_pkg::note_t         note,
  output logic [INDEX_W-1:0]       last_index
);

  import music_pkg::*;

  always_comb begin
    note       = '0;  // rest, zero length
    last_index = '0;
    case (section)
      SEC_INTRO: begin
        last_index = INDEX_W'(12);
        case (index)
          0:  note = '{10'd554, 4'd6};   // c5s
          1:  note = '{10'd622, 4'd10};  // e5f
          2:  note = '{10'd622, 4'd6};
          3:  note = '{10'd698, 4'd6};   // f5
          4:  note = '{10'd831, 4'd1};   // a5f
          5:  note = '{10'd740, 4'd1};   // f5s
          6:  note = '{10'd698, 4'd1};
          7:  note = '{10'd622, 4'd1};
          8:  note = '{10'd554, 4'd6};
          9:  note = '{10'd622, 4'd10};
          10: note = '{10'd0,   4'd4};   // rest
          11: note = '{10'd415, 4'd2};   // a4f
          12: note = '{10'd415, 4'd10};
          default: ;
        endcase
      end
      SEC_VERSE: begin
        last_index = INDEX_W'(15);
        case (index)
          0:  note = '{10'd0,   4'd6};   // rest
          1:  note = '{10'd277, 4'd1};   // c4s
          2:  note = '{10'd277, 4'd1};
          3:  note = '{10'd277, 4'd1};
          4:  note = '{10'd277, 4'd1};
          5:  note = '{10'd311, 4'd2};   // e4f
          6:  note = '{10'd0,   4'd1};
          7:  note = '{10'd261, 4'd1};   // c4
          8:  note = '{10'd233, 4'd1};   // b3f
          9:  note = '{10'd208, 4'd5};   // a3f
          10: note = '{10'd0,   4'd1};
          11: note = '{10'd233, 4'd1};
          12: note = '{10'd233, 4'd1};
          13: note = '{10'd261, 4'd1};
          14: note = '{10'd277, 4'd3};
          15: note = '{10'd208, 4'd1};
          default: ;
        endcase
      end
      SEC_CHORUS: begin
        last_index = INDEX_W'(15);
        case (index)
          0:  note = '{10'd466, 4'd1};   // b4f
          1:  note = '{10'd466, 4'd1};
          2:  note = '{10'd415, 4'd1};   // a4f
          3:  note = '{10'd415, 4'd1};
          4:  note = '{10'd698, 4'd3};   // f5
          5:  note = '{10'd698, 4'd3};
          6:  note = '{10'd622, 4'd6};   // e5f
          7:  note = '{10'd466, 4'd1};
          8:  note = '{10'd466, 4'd1};
          9:  note = '{10'd415, 4'd1};
          10: note = '{10'd415, 4'd1};
          11: note = '{10'd622, 4'd3};
          12: note = '{10'd622, 4'd3};
          13: note = '{10'd554, 4'd3};   // c5s
          14: note = '{10'd523, 4'd1};   // c5
          15: note = '{10'd466, 4'd2};
          default: ;
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/tone_gen.sv
`default_nettype none

module tone_gen #(
  parameter int ACC_W = 32
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire music_pkg::freq_t freq,
  input  wire music_pkg::cfg_t  cfg,
  output logic                  sound
);

  import music_pkg::*;

  logic [ACC_W-1:0] acc;
  logic [ACC_W-1:0] acc_next;
  logic [ACC_W-1:0] half;
  logic             sound_q;

  // ticks in half a second, one toggle per freq steps of it
  assign half     = ACC_W'(cfg.ticks_per_milli) * ACC_W'(MS_PER_HALF_SECOND);
  assign acc_next = acc + ACC_W'(freq);

  always_ff @(posedge clk) begin
    if (rst || freq == '0) begin
      acc     <= '0;
      sound_q <= 1'b0;
    end else if (acc >= half) begin
      acc     <= acc_next - half;
      sound_q <= ~sound_q;
    end else begin
      acc <= acc_next;
    end
  end

  assign sound = sound_q && (freq != '0);  // silent at once on a rest or gap

  a_acc_bound: assert property (
    @(posedge clk) disable iff (rst || !cfg.play)
    (freq != '0) |=> ({1'b0, acc} < {half, 1'b0})
  ) else $error("tone_gen: accumulator runaway");

endmodule

`default_nettype wire

// File: src.f
rtl/music_pkg.sv
rtl/music_regs.sv
rtl/milli_timer.sv
rtl/song_rom.sv
rtl/note_sequencer.sv
rtl/tone_gen.sv
rtl/seg_display.sv
rtl/music_top.sv
verif/music_tb.sv

// File: verif/music_tb.sv
`default_nettype none

module music_tb;

  import music_pkg::*;

  localparam logic [6:0] SEG_ZERO = 7'b0111111;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [3:0]  paddr = '0;
  logic        psel = 1'b0;
  logic        penable = 1'b0;
  logic        pwrite = 1'b0;
  logic [31:0] pwdata = '0;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        sound;
  logic [6:0]  segments;
  logic        dot;

  logic        exp_chk = 1'b0;  // compare prdata in this access
  logic [31:0] exp_data = '0;
  logic        exp_err = 1'b0;
  logic        sh_play;         // register model
  logic [15:0] sh_tpm;
  logic [9:0]  sh_beat;
  logic [9:0]  obs_freq = '0;   // last status.freq seen on the bus
  logic        sound_prev = 1'b0;
  logic [6:0]  seg_prev = SEG_ZERO;
  logic        armed = 1'b0;    // one toggle seen in this note
  int          span = 0;
  int          dot_len = 0;
  int          errors = 0;
  int          tone_checks = 0;
  int          stretches = 0;
  int          part_steps = 0;
  int          cycles = 0;
  int          limit = 0;
  logic [31:0] seed = 32'h1a81_e692;
  logic [15:0] tpm;
  logic [9:0]  beat;
  wire         apb_access = psel && penable;

  music_top #(.INDEX_W(5), .ACC_W(32)) dut0 (
    .clk(clk), .rst(rst),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .sound(sound), .segments(segments), .dot(dot)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic apb_error(input logic [3:0] a, input logic w);
    return !(a inside {4'h0, 4'h4, 4'h8, 4'hC}) || (w && a == 4'hC);
  endfunction

  function automatic logic [31:0] model_value(input logic [3:0] a);
    case (a)
      4'h0:    return {31'd0, sh_play};
      4'h4:    return {16'd0, sh_tpm};
      4'h8:    return {22'd0, sh_beat};
      default: return '0;  // status while stopped
    endcase
  endfunction

  function automatic int seg_digit(input logic [6:0] s);
    case (s)
      7'b0111111: return 0;
      7'b0000110: return 1;
      7'b1011011: return 2;
      7'b1001111: return 3;
      7'b1100110: return 4;
      7'b1101101: return 5;
      7'b1111100: return 6;
      default:    return -1;
    endcase
  endfunction

  function automatic int next_digit(input int d);
    return (d == 0 || d == NUM_PARTS) ? 1 : d + 1;
  endfunction

  // toggle spacing bounds, half a second of ticks per freq steps
  function automatic int min_spacing(input logic [15:0] t, input logic [9:0] f);
    return (int'(t) * MS_PER_HALF_SECOND) / int'(f);
  endfunction

  function automatic int max_spacing(input logic [15:0] t, input logic [9:0] f);
    return (int'(t) * MS_PER_HALF_SECOND + int'(f) - 1) / int'(f) + 1;
  endfunction

  // a whole number of beats, give or take a millisecond and two cycles
  function automatic logic whole_beats(input int len, input int ms, input int unit);
    int r;
    r = len % unit;
    return (len + ms + 2 >= unit) && (r <= ms + 2 || unit - r <= ms + 2);
  endfunction

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    errors++;
    $display("CHECK FAILED t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
  endtask

  task automatic record_failure(input string msg);
    errors++;
    $display("t=%0t %s", $time, msg);
  endtask

  task automatic bus_access(input logic [3:0] addr, input logic wr, input logic [31:0] data,
                            input logic chk);
    @(negedge clk);
    paddr    = addr;
    pwrite   = wr;
    pwdata   = data;
    psel     = 1'b1;
    exp_chk  = chk && !wr;
    exp_data = model_value(addr);
    exp_err  = apb_error(addr, wr);
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      sh_play <= 1'b0;
      sh_tpm  <= 16'd1000;
      sh_beat <= 10'd100;
    end else if (apb_access && pwrite) begin
      case (paddr)
        4'h0:    sh_play <= pwdata[0];
        4'h4:    sh_tpm  <= pwdata[15:0];
        4'h8:    sh_beat <= pwdata[9:0];
        default: ;
      endcase
    end
  end

  always @(posedge clk) begin
    cycles     <= cycles + 1;
    sound_prev <= sound;
    seg_prev   <= segments;
    dot_len    <= dot ? dot_len + 1 : 0;
    if (apb_access && !pwrite && paddr == 4'hC) begin
      obs_freq <= prdata[9:0];
    end
    if (rst || !dot) begin
      span  <= 0;
      armed <= 1'b0;
    end else if (sound != sound_prev) begin
      span  <= 1;
      armed <= 1'b1;
      if (armed && obs_freq != '0) begin
        tone_checks <= tone_checks + 1;
      end
    end else begin
      span <= span + 1;
    end
    if (sh_play && !dot && dot_len > 0) begin
      stretches <= stretches + 1;
    end
    if (!rst && sh_play && segments != seg_prev) begin
      part_steps <= part_steps + 1;
    end
    if (cycles > limit) begin
      $display("timeout: song did not wrap within %0d cycles", limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  a_pready: assert property (@(posedge clk) apb_access |-> pready)
    else show_mismatch("pready", 32'(pready), 32'd1);

  a_pslverr: assert property (@(posedge clk) disable iff (rst) apb_access |-> pslverr == exp_err)
    else show_mismatch("pslverr", 32'(pslverr), 32'(exp_err));

  a_prdata: assert property (@(posedge clk) disable iff (rst)
    apb_access && exp_chk |-> prdata == exp_data)
    else show_mismatch("prdata", prdata, exp_data);

  // quiet once play has been low for two edges
  a_quiet: assert property (@(posedge clk) disable iff (rst)
    !sh_play && !$past(sh_play) |-> {sound, dot, segments} == {2'b00, SEG_ZERO})
    else show_mismatch("sound,dot,segments", 32'({sound, dot, segments}), 32'(SEG_ZERO));

  a_gap_silent: assert property (@(posedge clk) disable iff (rst) !dot |-> !sound)
    else show_mismatch("sound", 32'(sound), 32'd0);

  a_tone_pitch: assert property (@(posedge clk) disable iff (rst)
    dot && armed && sound != sound_prev && obs_freq != '0 |->
      span >= min_spacing(sh_tpm, obs_freq) && span <= max_spacing(sh_tpm, obs_freq))
    else record_failure($sformatf("sound toggled after %0d cycles at %0d Hz, outside %0d..%0d",
      span, obs_freq, min_spacing(sh_tpm, obs_freq), max_spacing(sh_tpm, obs_freq)));

  a_note_len: assert property (@(posedge clk) disable iff (rst)
    sh_play && !dot && dot_len > 0 |->
      whole_beats(dot_len, int'(sh_tpm), int'(sh_beat) * int'(sh_tpm)))
    else record_failure($sformatf("dot was high for %0d cycles, not a whole number of beats",
      dot_len));

  a_part_order: assert property (@(posedge clk) disable iff (rst)
    sh_play && segments != seg_prev |-> seg_digit(segments) == next_digit(seg_digit(seg_prev)))
    else show_mismatch("part digit", seg_digit(segments), next_digit(seg_digit(seg_prev)));

  initial begin
    seed = lcg_next(seed);
    tpm  = 16'd20 + 16'(seed[23:8] % 16);
    seed = lcg_next(seed);
    beat = 10'd3 + 10'(seed[23:8] % 4);
    // up to 45 notes of 20 beats, a third more for gaps, twice over
    limit = 2 * 45 * 20 * 4 / 3 * int'(beat) * int'(tpm) + 1000;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    bus_access(4'h4, 1'b0, '0, 1'b1);  // reset values
    bus_access(4'h8, 1'b0, '0, 1'b1);
    bus_access(4'h0, 1'b1, 32'h0, 1'b0);
    bus_access(4'h0, 1'b0, '0, 1'b1);
    bus_access(4'h4, 1'b1, {seed[31:16], tpm}, 1'b0);
    bus_access(4'h8, 1'b1, {seed[15:0], 6'h2a, beat}, 1'b0);
    bus_access(4'h4, 1'b0, '0, 1'b1);
    bus_access(4'h8, 1'b0, '0, 1'b1);
    bus_access(4'hC, 1'b1, 32'h1fff, 1'b0);
    bus_access(4'h6, 1'b1, 32'hffff_ffff, 1'b0);
    bus_access(4'h2, 1'b0, '0, 1'b0);
    bus_access(4'h4, 1'b0, '0, 1'b1);
    bus_access(4'hC, 1'b0, '0, 1'b1);

    bus_access(4'h0, 1'b1, 32'h1, 1'b0);
    bus_access(4'h0, 1'b0, '0, 1'b1);
    while (part_steps < 7) begin
      bus_access(4'hC, 1'b0, '0, 1'b0);  // keeps obs_freq current
    end
    bus_access(4'h0, 1'b1, 32'h0, 1'b0);
    repeat (3) @(negedge clk);
    bus_access(4'hC, 1'b0, '0, 1'b1);
    bus_access(4'h0, 1'b0, '0, 1'b1);

    if (tone_checks == 0 || stretches == 0) begin
      record_failure("no tone spacing or note length was ever measured");
    end
    $display("summary: %0d errors, %0d tone spacings, %0d note stretches, %0d part steps",
             errors, tone_checks, stretches, part_steps);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
